// ==== Makefile ====
TOP := tb_bank_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the bank testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
	  --top-module $(TOP) -f bank_top.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// ==== bank_top.f ====
source/bank_pkg.sv
source/bank_htu.sv
source/bank_isu.sv
source/bank_sram_controller.sv
source/bank_wbuffer.sv
source/bank_top.sv
verif/tb_bank_top.sv

// ==== source/bank_htu.sv ====
`timescale 1ns/100ps
`default_nettype none

module bank_htu import bank_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  bank_req_t req_i,
  output logic      isu_valid_o,
  input  logic      isu_ready_i,
  output htu_isu_t  isu_o
);

  tag_t                tag_q [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] way_valid_q [NUM_SETS];
  way_idx_t            rr_ptr_q [NUM_SETS];

  logic                req_ready_q;
  logic                isu_valid_q;
  logic                valid_d;
  htu_isu_t            isu_q;

  tag_t                req_tag;
  set_idx_t            req_set;
  logic                req_half;
  logic [NUM_WAYS-1:0] hit_vec;
  logic                lookup_hit;
  way_idx_t            hit_way;
  way_idx_t            sel_way;
  logic                accept;

  assign req_tag  = req_i.addr[31:9];
  assign req_set  = req_i.addr[8:5];
  assign req_half = req_i.addr[4];

  // --------------------------------------
  // Tag compare
  // --------------------------------------
  always_comb begin
    hit_vec = '0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_valid_q[req_set][w] && (tag_q[req_set][w] == req_tag)) begin
        hit_vec[w] = 1'b1;
        hit_way    = way_idx_t'(w);
      end
    end
  end

  assign lookup_hit = |hit_vec;
  // A miss takes the way the round-robin pointer of this set points at
  assign sel_way    = lookup_hit ? hit_way : rr_ptr_q[req_set];

  // --------------------------------------
  // Handshake
  // --------------------------------------
  assign accept  = req_valid_i && req_ready_q;
  assign valid_d = accept || (isu_valid_q && !isu_ready_i);

  // Ready is registered so that it comes up one cycle after reset
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      req_ready_q <= 1'b0;
      isu_valid_q <= 1'b0;
    end else begin
      req_ready_q <= !valid_d;
      isu_valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        way_valid_q[s] <= '0;
        rr_ptr_q[s]    <= '0;
      end
    end else if (accept && !lookup_hit) begin
      way_valid_q[req_set][sel_way] <= 1'b1;
      rr_ptr_q[req_set]             <= rr_ptr_q[req_set] + way_idx_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (!lookup_hit) begin
        tag_q[req_set][sel_way] <= req_tag;
      end
      isu_q.ch_id       <= req_i.ch_id;
      isu_q.op          <= req_i.op;
      isu_q.set_way_off <= {req_set, sel_way, req_half};
      isu_q.wbuf_id     <= req_i.wbuf_id;
      isu_q.hit         <= lookup_hit;
    end
  end

  assign req_ready_o = req_ready_q;
  assign isu_valid_o = isu_valid_q;
  assign isu_o       = isu_q;

endmodule

`default_nettype wire

// ==== source/bank_isu.sv ====
`timescale 1ns/100ps
`default_nettype none

module bank_isu import bank_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     htu_valid_i,
  output logic     htu_ready_o,
  input  htu_isu_t htu_i,
  output logic     sc_valid_o,
  input  logic     sc_ready_i,
  output isu_sc_t  sc_o
);

  // Two entries keep two requests in flight towards the controller
  isu_sc_t    fifo_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  rob_num_t   rob_cnt_q [NUM_CH];
  isu_sc_t    new_entry;
  logic       push;
  logic       pop;

  assign htu_ready_o = (count_q != 2'd2);
  assign sc_valid_o  = (count_q != 2'd0);
  assign sc_o        = fifo_q[rd_ptr_q];

  assign push = htu_valid_i && htu_ready_o;
  assign pop  = sc_valid_o && sc_ready_i;

  // Stamp the item with the current order number of its channel
  always_comb begin
    new_entry.ch_id       = htu_i.ch_id;
    new_entry.op          = htu_i.op;
    new_entry.set_way_off = htu_i.set_way_off;
    new_entry.wbuf_id     = htu_i.wbuf_id;
    new_entry.hit         = htu_i.hit;
    new_entry.rob_num     = rob_cnt_q[htu_i.ch_id];
  end

  // --------------------------------------
  // Queue control and order counters
  // --------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
      for (int c = 0; c < NUM_CH; c++) begin
        rob_cnt_q[c] <= '0;
      end
    end else begin
      if (push) begin
        wr_ptr_q                 <= !wr_ptr_q;
        rob_cnt_q[htu_i.ch_id]   <= rob_cnt_q[htu_i.ch_id] + rob_num_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= new_entry;
    end
  end

endmodule

`default_nettype wire

// ==== source/bank_pkg.sv ====
`default_nettype none

package bank_pkg;

  // --------------------------------------
  // Geometry
  // --------------------------------------
  localparam int NUM_SETS   = 16;
  localparam int NUM_WAYS   = 4;
  localparam int NUM_CH     = 4;
  localparam int WBUF_DEPTH = 16;
  localparam int DATA_W     = 128;
  localparam int TAG_W      = 23;

  // --------------------------------------
  // Vector types
  // --------------------------------------
  typedef logic [$clog2(NUM_CH)-1:0]   ch_id_t;
  typedef logic [31:4]                 line_addr_t;
  typedef logic [TAG_W-1:0]            tag_t;
  typedef logic [$clog2(NUM_SETS)-1:0] set_idx_t;
  typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;
  // Set in the upper bits, then way, then the half select in bit 0
  typedef logic [6:0]                  set_way_off_t;
  typedef logic [7:0]                  wbuf_id_t;
  typedef logic [2:0]                  rob_num_t;
  typedef logic [DATA_W-1:0]           data_t;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1
  } bank_op_e;

  // --------------------------------------
  // Link payloads
  // --------------------------------------
  typedef struct packed {
    ch_id_t     ch_id;
    bank_op_e   op;
    line_addr_t addr;
    wbuf_id_t   wbuf_id;
  } bank_req_t;

  typedef struct packed {
    ch_id_t       ch_id;
    bank_op_e     op;
    set_way_off_t set_way_off;
    wbuf_id_t     wbuf_id;
    logic         hit;
  } htu_isu_t;

  typedef struct packed {
    ch_id_t       ch_id;
    bank_op_e     op;
    set_way_off_t set_way_off;
    wbuf_id_t     wbuf_id;
    logic         hit;
    rob_num_t     rob_num;
  } isu_sc_t;

  typedef struct packed {
    ch_id_t   ch_id;
    rob_num_t rob_num;
    data_t    data;
  } bank_rsp_t;

  typedef struct packed {
    wbuf_id_t wbuf_id;
    data_t    data;
  } wbuf_fill_t;

endpackage

`default_nettype wire

// ==== source/bank_sram_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module bank_sram_controller import bank_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      isu_valid_i,
  output logic      isu_ready_o,
  input  isu_sc_t   isu_i,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output bank_rsp_t rsp_o,
  output logic      wbuf_req_valid_o,
  input  logic      wbuf_req_ready_i,
  output wbuf_id_t  wbuf_req_id_o,
  input  logic      wbuf_rtn_valid_i,
  output logic      wbuf_rtn_ready_o,
  input  data_t     wbuf_rtn_data_i
);

  typedef enum logic [2:0] {
    IDLE,
    CLEAR,
    READ,
    WBUF_REQ,
    WBUF_RTN,
    RESP
  } sc_state_e;

  sc_state_e    state_q;
  sc_state_e    state_d;
  isu_sc_t      item_q;
  data_t        rsp_data_q;
  data_t        data_q [NUM_SETS*NUM_WAYS*2];
  set_way_off_t half_lo;
  set_way_off_t half_hi;
  logic         accept;

  assign isu_ready_o = (state_q == IDLE);
  assign accept      = isu_valid_i && isu_ready_o;

  // Both halves of the line that the current item addresses
  assign half_lo = {item_q.set_way_off[6:1], 1'b0};
  assign half_hi = {item_q.set_way_off[6:1], 1'b1};

  // --------------------------------------
  // State machine
  // --------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (isu_valid_i) begin
          if (!isu_i.hit) begin
            state_d = CLEAR;
          end else if (isu_i.op == OP_WRITE) begin
            state_d = WBUF_REQ;
          end else begin
            state_d = READ;
          end
        end
      end
      CLEAR:    state_d = (item_q.op == OP_WRITE) ? WBUF_REQ : READ;
      READ:     state_d = RESP;
      WBUF_REQ: if (wbuf_req_ready_i) state_d = WBUF_RTN;
      WBUF_RTN: if (wbuf_rtn_valid_i) state_d = RESP;
      RESP:     if (rsp_ready_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------
  // Data array and response data
  // --------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      item_q <= isu_i;
    end
    // A freshly allocated line starts out all zero
    if (state_q == CLEAR) begin
      data_q[half_lo] <= '0;
      data_q[half_hi] <= '0;
    end
    if (state_q == READ) begin
      rsp_data_q <= data_q[item_q.set_way_off];
    end
    if ((state_q == WBUF_RTN) && wbuf_rtn_valid_i) begin
      data_q[item_q.set_way_off] <= wbuf_rtn_data_i;
      rsp_data_q                 <= wbuf_rtn_data_i;
    end
  end

  assign wbuf_req_valid_o = (state_q == WBUF_REQ);
  assign wbuf_req_id_o    = item_q.wbuf_id;
  assign wbuf_rtn_ready_o = (state_q == WBUF_RTN);

  assign rsp_valid_o = (state_q == RESP);

  always_comb begin
    rsp_o.ch_id   = item_q.ch_id;
    rsp_o.rob_num = item_q.rob_num;
    rsp_o.data    = rsp_data_q;
  end

endmodule

`default_nettype wire

// ==== source/bank_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bank_top import bank_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  bank_req_t  req_i,
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output bank_rsp_t  rsp_o,
  input  logic       wbuf_fill_valid_i,
  input  wbuf_fill_t wbuf_fill_i
);

  logic     htu_isu_valid;
  logic     htu_isu_ready;
  htu_isu_t htu_isu;

  logic     isu_sc_valid;
  logic     isu_sc_ready;
  isu_sc_t  isu_sc;

  logic     rc_wbuf_req_valid;
  logic     rc_wbuf_req_ready;
  wbuf_id_t rc_wbuf_req_id;
  logic     rc_wbuf_rtn_valid;
  logic     rc_wbuf_rtn_ready;
  data_t    rc_wbuf_rtn_data;

  // --------------------------------------
  // Hit test unit
  // --------------------------------------
  bank_htu u_bank_htu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .isu_valid_o (htu_isu_valid),
    .isu_ready_i (htu_isu_ready),
    .isu_o       (htu_isu)
  );

  // --------------------------------------
  // Issue unit
  // --------------------------------------
  bank_isu u_bank_isu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .htu_valid_i (htu_isu_valid),
    .htu_ready_o (htu_isu_ready),
    .htu_i       (htu_isu),
    .sc_valid_o  (isu_sc_valid),
    .sc_ready_i  (isu_sc_ready),
    .sc_o        (isu_sc)
  );

  // --------------------------------------
  // SRAM controller
  // --------------------------------------
  bank_sram_controller u_bank_sram_controller (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .isu_valid_i      (isu_sc_valid),
    .isu_ready_o      (isu_sc_ready),
    .isu_i            (isu_sc),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_ready_i      (rsp_ready_i),
    .rsp_o            (rsp_o),
    .wbuf_req_valid_o (rc_wbuf_req_valid),
    .wbuf_req_ready_i (rc_wbuf_req_ready),
    .wbuf_req_id_o    (rc_wbuf_req_id),
    .wbuf_rtn_valid_i (rc_wbuf_rtn_valid),
    .wbuf_rtn_ready_o (rc_wbuf_rtn_ready),
    .wbuf_rtn_data_i  (rc_wbuf_rtn_data)
  );

  // --------------------------------------
  // Write buffer
  // --------------------------------------
  bank_wbuffer u_bank_wbuffer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .fill_valid_i (wbuf_fill_valid_i),
    .fill_i       (wbuf_fill_i),
    .req_valid_i  (rc_wbuf_req_valid),
    .req_ready_o  (rc_wbuf_req_ready),
    .req_id_i     (rc_wbuf_req_id),
    .rtn_valid_o  (rc_wbuf_rtn_valid),
    .rtn_ready_i  (rc_wbuf_rtn_ready),
    .rtn_data_o   (rc_wbuf_rtn_data)
  );

endmodule

`default_nettype wire

// ==== source/bank_wbuffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module bank_wbuffer import bank_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       fill_valid_i,
  input  wbuf_fill_t fill_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  wbuf_id_t   req_id_i,
  output logic       rtn_valid_o,
  input  logic       rtn_ready_i,
  output data_t      rtn_data_o
);

  data_t mem_q [WBUF_DEPTH];
  data_t rtn_data_q;
  logic  rtn_valid_q;
  logic  req_fire;

  // Only one read is outstanding, so a pending return blocks new requests
  assign req_ready_o = !rtn_valid_q;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rtn_valid_q <= 1'b0;
    end else if (req_fire) begin
      rtn_valid_q <= 1'b1;
    end else if (rtn_valid_q && rtn_ready_i) begin
      rtn_valid_q <= 1'b0;
    end
  end

  // The low id bits select the entry
  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      mem_q[fill_i.wbuf_id[$clog2(WBUF_DEPTH)-1:0]] <= fill_i.data;
    end
    if (req_fire) begin
      rtn_data_q <= mem_q[req_id_i[$clog2(WBUF_DEPTH)-1:0]];
    end
  end

  assign rtn_valid_o = rtn_valid_q;
  assign rtn_data_o  = rtn_data_q;

endmodule

`default_nettype wire

// ==== verif/tb_bank_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_bank_top import bank_pkg::*; ();

  localparam int NUM_REQS      = 400;
  localparam int SWEEP_REQS    = 32;
  localparam int TIMEOUT_CYC   = NUM_REQS * 20;
  localparam int TAG_POOL      = 5;
  // One item in the controller, two in the issue queue and one in the hit test unit
  localparam int MAX_IN_FLIGHT = 4;

  logic       clk_i = 1'b0;
  logic       rst_i = 1'b1;
  logic       req_valid_i = 1'b0;
  logic       req_ready_o;
  bank_req_t  req_i = '0;
  logic       rsp_valid_o;
  logic       rsp_ready_i = 1'b0;
  bank_rsp_t  rsp_o;
  logic       wbuf_fill_valid_i = 1'b0;
  wbuf_fill_t wbuf_fill_i = '0;

  // Reference model of tags, line halves, write buffer and order numbers
  tag_t      ref_tag [NUM_SETS][NUM_WAYS];
  logic      ref_vld [NUM_SETS][NUM_WAYS];
  way_idx_t  ref_ptr [NUM_SETS];
  data_t     ref_half [NUM_SETS*NUM_WAYS*2];
  data_t     ref_wbuf [WBUF_DEPTH];
  rob_num_t  ref_rob [NUM_CH];
  int        wbuf_pending [WBUF_DEPTH];
  bank_rsp_t exp_q [$];
  int        exp_wid_q [$];

  logic [31:0] rng;
  int          cycle_cnt = 0;
  int          n_issued;
  int          n_accepted;
  int          prefill_cnt;
  int          stall_left;
  int          ready_phase;
  int          rsp_stall_run;
  int          n_evict;
  int          n_write;
  int          n_read_hit_data;
  logic        req_taken;
  logic        saw_backpressure;
  logic        prev_valid;
  logic        prev_fired;
  bank_rsp_t   prev_rsp;

  bank_top dut (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .req_i             (req_i),
    .rsp_valid_o       (rsp_valid_o),
    .rsp_ready_i       (rsp_ready_i),
    .rsp_o             (rsp_o),
    .wbuf_fill_valid_i (wbuf_fill_valid_i),
    .wbuf_fill_i       (wbuf_fill_i)
  );

  always #20 clk_i = ~clk_i;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic compare_field(input string name, input data_t expected, input data_t actual);
    assert (actual === expected) else
      report_error($sformatf("[FAIL] %s expected %h got %h", name, expected, actual));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // A small pool of tags per set forces misses and evictions
  function automatic tag_t pool_tag(input int idx);
    return tag_t'(32'h0005_a3c1 * (idx + 1));
  endfunction

  // --------------------------------------
  // Stimulus
  // --------------------------------------
  task automatic next_request();
    bank_req_t   r;
    logic [31:0] x;
    x = rand32();
    r.ch_id   = x[4:3];
    r.wbuf_id = x[12:5];
    r.op      = x[16] ? OP_WRITE : OP_READ;
    r.addr    = {pool_tag(int'(x[15:13]) % TAG_POOL), x[20:17], x[21]};
    // Directed sweep over every set and half after reset
    if (n_issued < SWEEP_REQS) begin
      r.op   = OP_READ;
      r.addr = {pool_tag(int'(x[15:13]) % TAG_POOL), set_idx_t'(n_issued / 2), n_issued[0]};
    end
    if (req_valid_i && !req_taken) begin
      req_valid_i <= 1'b1;
    end else if (n_issued >= NUM_REQS || (n_issued >= SWEEP_REQS && x[2:0] == 3'd0)) begin
      req_valid_i <= 1'b0;
    end else begin
      req_i       <= r;
      req_valid_i <= 1'b1;
      n_issued++;
    end
  endtask

  task automatic next_fill();
    wbuf_fill_t  f;
    logic [31:0] x;
    logic        fill;
    x         = rand32();
    fill      = 1'b0;
    f.wbuf_id = {x[15:12], x[11:8]};
    f.data    = {rand32(), rand32(), rand32(), rand32()};
    if (prefill_cnt < WBUF_DEPTH) begin
      f.wbuf_id = {x[7:4], prefill_cnt[3:0]};
      fill      = 1'b1;
      prefill_cnt++;
    end else if (x[1:0] == 2'd0 && wbuf_pending[x[11:8]] == 0) begin
      // Entries with a write in flight are left alone
      fill = 1'b1;
    end
    wbuf_fill_i       <= f;
    wbuf_fill_valid_i <= fill;
  endtask

  task automatic pace_response_ready();
    logic [31:0] x;
    x = rand32();
    if (stall_left > 0) begin
      stall_left--;
    end else if (x[6:0] == 7'd0) begin
      stall_left = 32 + int'(x[12:8]);
    end
    ready_phase = (ready_phase == 2) ? 0 : ready_phase + 1;
    rsp_ready_i <= (stall_left == 0) && (ready_phase == 0);
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      rng         = 32'he7a7_138c;
      n_issued    = 0;
      prefill_cnt = 0;
      stall_left  = 0;
      ready_phase = 0;
      req_valid_i       <= 1'b0;
      rsp_ready_i       <= 1'b0;
      wbuf_fill_valid_i <= 1'b0;
    end else begin
      next_fill();
      next_request();
      pace_response_ready();
    end
  end

  // --------------------------------------
  // Reference model and checks
  // --------------------------------------
  task automatic reset_model();
    for (int s = 0; s < NUM_SETS; s++) begin
      ref_ptr[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        ref_vld[s][w] = 1'b0;
        ref_tag[s][w] = '0;
      end
    end
    for (int i = 0; i < NUM_SETS*NUM_WAYS*2; i++) begin
      ref_half[i] = '0;
    end
    for (int i = 0; i < WBUF_DEPTH; i++) begin
      ref_wbuf[i]     = '0;
      wbuf_pending[i] = 0;
    end
    for (int c = 0; c < NUM_CH; c++) begin
      ref_rob[c] = '0;
    end
    exp_q.delete();
    exp_wid_q.delete();
    n_accepted       = 0;
    n_evict          = 0;
    n_write          = 0;
    n_read_hit_data  = 0;
    rsp_stall_run    = 0;
    saw_backpressure = 1'b0;
    req_taken        = 1'b0;
    prev_valid       = 1'b0;
    prev_fired       = 1'b0;
    prev_rsp         = '0;
  endtask

  task automatic accept_request();
    tag_t      t;
    set_idx_t  s;
    way_idx_t  w;
    logic      hit;
    int        idx;
    bank_rsp_t e;
    t   = req_i.addr[31:9];
    s   = req_i.addr[8:5];
    w   = '0;
    hit = 1'b0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (ref_vld[s][i] && ref_tag[s][i] == t) begin
        hit = 1'b1;
        w   = way_idx_t'(i);
      end
    end
    // A miss takes the oldest way of the set and starts it at zero
    if (!hit) begin
      w = ref_ptr[s];
      if (ref_vld[s][w]) begin
        n_evict++;
      end
      ref_tag[s][w] = t;
      ref_vld[s][w] = 1'b1;
      ref_ptr[s]    = ref_ptr[s] + 2'd1;
      ref_half[{s, w, 1'b0}] = '0;
      ref_half[{s, w, 1'b1}] = '0;
    end
    idx = int'({s, w, req_i.addr[4]});
    if (req_i.op == OP_WRITE) begin
      ref_half[idx] = ref_wbuf[req_i.wbuf_id[3:0]];
      wbuf_pending[req_i.wbuf_id[3:0]]++;
      exp_wid_q.push_back(int'(req_i.wbuf_id[3:0]));
      n_write++;
    end else begin
      if (hit && ref_half[idx] != '0) begin
        n_read_hit_data++;
      end
      exp_wid_q.push_back(-1);
    end
    e.ch_id   = req_i.ch_id;
    e.rob_num = ref_rob[req_i.ch_id];
    e.data    = ref_half[idx];
    ref_rob[req_i.ch_id] = ref_rob[req_i.ch_id] + 3'd1;
    exp_q.push_back(e);
    n_accepted++;
  endtask

  task automatic watch_response();
    bank_rsp_t e;
    int        wid;
    // A stalled response must hold still until it is taken
    if (prev_valid && !prev_fired) begin
      assert (rsp_valid_o) else
        report_error("Response valid dropped before the response was taken");
      assert (rsp_o == prev_rsp) else
        report_error($sformatf("[FAIL] rsp_o expected %h got %h", prev_rsp, rsp_o));
    end
    if (rsp_valid_o && rsp_ready_i) begin
      assert (exp_q.size() > 0) else
        report_error("A response came out with no request outstanding");
      e   = exp_q.pop_front();
      wid = exp_wid_q.pop_front();
      compare_field("rsp_o.ch_id", data_t'(e.ch_id), data_t'(rsp_o.ch_id));
      compare_field("rsp_o.rob_num", data_t'(e.rob_num), data_t'(rsp_o.rob_num));
      compare_field("rsp_o.data", e.data, rsp_o.data);
      if (wid >= 0) begin
        wbuf_pending[wid]--;
      end
    end
    prev_valid = rsp_valid_o;
    prev_fired = rsp_valid_o && rsp_ready_i;
    prev_rsp   = rsp_o;
  endtask

  // Inputs and outputs are settled at the falling edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      assert (!rsp_valid_o) else
        report_error("Response valid was high during reset");
      reset_model();
    end else begin
      if (wbuf_fill_valid_i) begin
        ref_wbuf[wbuf_fill_i.wbuf_id[3:0]] = wbuf_fill_i.data;
      end
      watch_response();
      req_taken = req_valid_i && req_ready_o;
      if (req_taken) begin
        accept_request();
      end
      // A stalled response must make the bank stop taking requests
      assert (exp_q.size() <= MAX_IN_FLIGHT) else
        report_error("The bank took more requests than it can hold while responses waited");
      rsp_stall_run = (rsp_valid_o && !rsp_ready_i) ? rsp_stall_run + 1 : 0;
      if (rsp_stall_run >= 8 && !req_ready_o) begin
        saw_backpressure = 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      report_error($sformatf("Timeout after %0d cycles with %0d requests accepted and %0d open",
                             cycle_cnt, n_accepted, exp_q.size()));
    end
  end

  initial begin
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    while (n_accepted < NUM_REQS || exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    assert (!rsp_valid_o) else
      report_error("A response was still valid after the last expected one was taken");
    if (saw_backpressure && n_evict > 0 && n_write > 0 && n_read_hit_data > 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      report_error("The run ended without reaching eviction, writes, read hits or a full stall");
    end
  end

endmodule

`default_nettype wire
